// File: tb.f
+incdir+hw
+incdir+tests
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/insDecoder.sv
hw/cuSequencer.sv
hw/ctrlWordRom.sv
hw/controlUnit.sv
tests/tbControlUnit.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/isaPkg.sv
      - hw/ctrlPkg.sv
      - hw/insDecoder.sv
      - hw/cuSequencer.sv
      - hw/ctrlWordRom.sv
      - hw/controlUnit.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tbControlUnit.sv

// File: tests/cuModel.svh
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

// Write-enable masks, one register each
localparam logic [12:0] W_PC = 13'h1000;
localparam logic [12:0] W_IR = 13'h0800;
localparam logic [12:0] W_AR = 13'h0400;
localparam logic [12:0] W_DR = 13'h0200;
localparam logic [12:0] W_P  = 13'h0100;
localparam logic [12:0] W_T  = 13'h0080;
localparam logic [12:0] W_M1 = 13'h0040;
localparam logic [12:0] W_K1 = 13'h0020;
localparam logic [12:0] W_N1 = 13'h0010;
localparam logic [12:0] W_C1 = 13'h0008;
localparam logic [12:0] W_C2 = 13'h0004;
localparam logic [12:0] W_C3 = 13'h0002;
localparam logic [12:0] W_AC = 13'h0001;

// Bus source codes
localparam logic [3:0] B_NONE = 4'd0;
localparam logic [3:0] B_AC   = 4'd1;
localparam logic [3:0] B_C3   = 4'd2;
localparam logic [3:0] B_C2   = 4'd3;
localparam logic [3:0] B_C1   = 4'd4;
localparam logic [3:0] B_M2   = 4'd7;
localparam logic [3:0] B_M1   = 4'd10;
localparam logic [3:0] B_T    = 4'd11;
localparam logic [3:0] B_P    = 4'd12;
localparam logic [3:0] B_DR   = 4'd13;
localparam logic [3:0] B_AR   = 4'd14;
localparam logic [3:0] B_MEM  = 4'd15;

// Strobe bits in the order iRomRead, memRead, memWrite, selAr
localparam logic [3:0] S_ROM = 4'b1000;
localparam logic [3:0] S_MRD = 4'b0100;
localparam logic [3:0] S_MWR = 4'b0010;
localparam logic [3:0] S_SAR = 4'b0001;

localparam logic [5:0] I_PC  = 6'b100000;
localparam logic [2:0] A_SET = 3'b001;
localparam logic [2:0] A_MUL = 3'b010;
localparam logic [2:0] A_ADD = 3'b100;

cuStateT              mState;
logic [3:0]           expStrobes;
wenMaskT              expWen;
busSelT               expBus;
logic [`CU_INC_W-1:0] expInc;
logic [`CU_RST_W-1:0] expRst;
logic [`CU_CMP_W-1:0] expCmp;
aluOpT                expAlu;

task automatic setWord(input logic [3:0] strobes, input logic [12:0] wen,
                       input logic [3:0] bus, input logic [5:0] inc,
                       input logic [4:0] clr, input logic [2:0] cmp,
                       input logic [2:0] alu);
    expStrobes = strobes;
    expWen     = wen;
    expBus     = busSelT'(bus);
    expInc     = inc;
    expRst     = clr;
    expCmp     = cmp;
    expAlu     = aluOpT'(alu);
endtask

// Expected control word of one state
task automatic modelWord(input cuStateT s);
    case (s)
        FETCH1, JMP2, COPY1, ASSIGN1: setWord(S_ROM, '0, B_NONE, '0, '0, '0, '0);
        FETCH2:         setWord('0, W_IR, B_NONE, I_PC, '0, '0, '0);
        FETCH3, NJMP1:  setWord('0, '0, B_NONE, I_PC, '0, '0, '0);
        JMPM1:          setWord('0, '0, B_NONE, '0, '0, 3'b100, '0);
        JMPK1:          setWord('0, '0, B_NONE, '0, '0, 3'b010, '0);
        JMPN1:          setWord('0, '0, B_NONE, '0, '0, 3'b001, '0);
        JMP3:           setWord('0, W_AR, B_NONE, '0, '0, '0, '0);
        JMP4:           setWord('0, W_PC, B_AR, '0, '0, '0, '0);
        COPY2, ASSIGN2: setWord(S_SAR, W_AR, B_NONE, I_PC, '0, '0, '0);
        COPY3, LOAD2:   setWord(S_MRD, '0, B_NONE, '0, '0, '0, '0);
        COPY4, LOAD3:   setWord('0, W_DR, B_MEM, '0, '0, '0, '0);
        COPYM5:         setWord('0, W_M1, B_DR, '0, '0, '0, '0);
        COPYK5:         setWord('0, W_K1, B_DR, '0, '0, '0, '0);
        COPYN5:         setWord('0, W_N1, B_DR, '0, '0, '0, '0);
        LOADC1:         setWord('0, W_AR, B_C1, '0, '0, '0, '0);
        LOADC2:         setWord('0, W_AR, B_C2, '0, '0, '0, '0);
        STORE1:         setWord('0, W_DR, B_T, '0, '0, '0, '0);
        STORE2:         setWord('0, W_AR, B_C3, '0, '0, '0, '0);
        STORE3:         setWord(S_MWR, '0, B_DR, '0, '0, '0, '0);
        ASSIGNC1:       setWord('0, W_C1, B_AR, '0, '0, '0, '0);
        ASSIGNC2:       setWord('0, W_C2, B_AR, '0, '0, '0, '0);
        ASSIGNC3:       setWord('0, W_C3, B_AR, '0, '0, '0, '0);
        RESETALL:       setWord('0, '0, B_NONE, '0, 5'b11111, '0, '0);
        RESETN2:        setWord('0, '0, B_NONE, '0, 5'b00010, '0, '0);
        RESETK2:        setWord('0, '0, B_NONE, '0, 5'b00100, '0, '0);
        MOVEP:          setWord('0, W_P, B_AC, '0, '0, '0, '0);
        MOVET:          setWord('0, W_T, B_AC, '0, '0, '0, '0);
        MOVEC1:         setWord('0, W_C1, B_AC, '0, '0, '0, '0);
        SETC1:          setWord('0, W_AC, B_C1, '0, '0, '0, A_SET);
        SETDR:          setWord('0, W_AC, B_DR, '0, '0, '0, A_SET);
        MUL1:           setWord('0, W_AC, B_P, '0, '0, '0, A_MUL);
        ADDRT:          setWord('0, W_AC, B_T, '0, '0, '0, A_ADD);
        ADDRM1:         setWord('0, W_AC, B_M1, '0, '0, '0, A_ADD);
        ADDRM2:         setWord('0, W_AC, B_M2, '0, '0, '0, A_ADD);
        default:        setWord('0, '0, B_NONE, '0, '0, '0, '0); // NOOP
    endcase
endtask

// First execute state of an instruction byte
function automatic cuStateT modelEntry(input logic [7:0] ins);
    logic [3:0] sub;
    cuStateT    e;
    sub = ins[3:0];
    case (ins[7:4])
        4'd1:    e = (sub == 0) ? JMPM1 : (sub == 1) ? JMPK1 : (sub == 2) ? JMPN1 : NOOP;
        4'd2:    e = COPY1;
        4'd3:    e = (sub == 0) ? LOADC1 : (sub == 1) ? LOADC2 : NOOP;
        4'd4:    e = STORE1;
        4'd5:    e = ASSIGN1;
        4'd6:    e = (sub == 0) ? RESETALL : (sub == 1) ? RESETN2 : (sub == 2) ? RESETK2 : NOOP;
        4'd7:    e = (sub == 0) ? MOVEP : (sub == 1) ? MOVET : (sub == 2) ? MOVEC1 : NOOP;
        4'd8:    e = (sub == 0) ? SETC1 : (sub == 1) ? SETDR : NOOP;
        4'd9:    e = MUL1;
        4'd10:   e = (sub == 0) ? ADDRT : (sub == 1) ? ADDRM1 : (sub == 2) ? ADDRM2 : NOOP;
        default: e = NOOP;
    endcase
    return e;
endfunction

function automatic cuStateT modelNext(input cuStateT cur, input logic [7:0] ins,
                                      input logic z);
    logic [1:0] tgt;
    tgt = ins[1:0];
    case (cur)
        FETCH1:              return FETCH2;
        FETCH2:              return FETCH3;
        FETCH3:              return modelEntry(ins);
        JMPM1, JMPK1, JMPN1: return z ? NJMP1 : JMP2;
        JMP2:                return JMP3;
        JMP3:                return JMP4;
        COPY1:               return COPY2;
        COPY2:               return COPY3;
        COPY3:               return COPY4;
        COPY4:               return (tgt == 0) ? COPYM5 : (tgt == 1) ? COPYK5 :
                                    (tgt == 2) ? COPYN5 : FETCH1;
        LOADC1, LOADC2:      return LOAD2;
        LOAD2:               return LOAD3;
        STORE1:              return STORE2;
        STORE2:              return STORE3;
        ASSIGN1:             return ASSIGN2;
        ASSIGN2:             return (tgt == 0) ? ASSIGNC1 : (tgt == 1) ? ASSIGNC2 :
                                    (tgt == 2) ? ASSIGNC3 : FETCH1;
        default:             return FETCH1; // NOOP and last states
    endcase
endfunction

// One clock edge of the reference
task automatic stepModel(input logic inRst, input logic [7:0] ins, input logic z);
    if (inRst) begin
        mState = NOOP;
    end else begin
        mState = modelNext(mState, ins, z);
    end
    modelWord(mState);
endtask

`endif

// File: tests/tbControlUnit.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module tbControlUnit
    import isaPkg::*;
    import ctrlPkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int DRV_DLY    = 2;
    localparam int RST_CYCLES = 3;
    localparam int NUM_INS    = 400;
    localparam int MAX_CYC    = 8; // Longest instruction, COPY

    logic                 Clk = 1'b0;
    logic                 rst;
    insWordT              regIr;
    logic                 zero;
    logic                 iRomRead;
    logic                 memRead;
    logic                 memWrite;
    logic                 selAr;
    wenMaskT              wEn;
    busSelT               busSel;
    logic [`CU_INC_W-1:0] incEn;
    logic [`CU_RST_W-1:0] rstEn;
    logic [`CU_CMP_W-1:0] compSel;
    aluOpT                aluOp;

    int   insDone = 0;
    int   sinceIr = 0; // Cycles since the last IR write
    logic jmpZero = 1'b0;

    `include "cuModel.svh"

    controlUnit u_dut (
        .Clk      (Clk),
        .rst      (rst),
        .regIr    (regIr),
        .zero     (zero),
        .iRomRead (iRomRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .selAr    (selAr),
        .wEn      (wEn),
        .busSel   (busSel),
        .incEn    (incEn),
        .rstEn    (rstEn),
        .compSel  (compSel),
        .aluOp    (aluOp)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWen(input string name, input wenMaskT exp, input wenMaskT act);
        if (act !== exp) begin
            $display("ERROR %s wEn: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkBusSel(input string name, input busSelT exp, input busSelT act);
        if (act !== exp) begin
            $display("ERROR %s busSel: expected %0d, actual %0d", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkAluOp(input string name, input aluOpT exp, input aluOpT act);
        if (act !== exp) begin
            $display("ERROR %s aluOp: expected %b, actual %b", name, exp, act);
            abortRun();
        end
    endtask

    // iRomRead, memRead, memWrite, selAr
    task automatic checkStrobes(input string name, input logic [3:0] exp,
                                input logic [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s strobes: expected %b, actual %b", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkField(input string name, input logic [`CU_INC_W-1:0] exp,
                              input logic [`CU_INC_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            abortRun();
        end
    endtask

    function automatic string testName(input cuStateT s);
        string grp;
        case (s)
            NOOP:                   grp = "noop";
            FETCH1, FETCH2, FETCH3: grp = "fetch";
            JMPM1, JMPK1, JMPN1, JMP2, JMP3, JMP4, NJMP1: grp = "jump";
            RESETALL, RESETN2, RESETK2, MOVEP, MOVET, MOVEC1,
            SETC1, SETDR, MUL1, ADDRT, ADDRM1, ADDRM2: grp = "register op";
            default:                grp = "memory transfer";
        endcase
        if (rst) begin
            grp = "reset";
        end
        return {grp, " ", s.name()};
    endfunction

    // Highest legal variant, 15 where the group ignores it
    function automatic int maxSubOp(input logic [3:0] op);
        case (op)
            4'd1, 4'd6, 4'd7, 4'd10: return 2;
            4'd3, 4'd8:              return 1;
            default:                 return 15;
        endcase
    endfunction

    // Roughly one byte in six is illegal
    function automatic logic [7:0] randomInstruction();
        logic [3:0] op;
        logic [3:0] sub;
        if ($urandom_range(5, 0) == 0) begin
            if ($urandom_range(1, 0) == 1) begin
                op  = 4'($urandom_range(15, 11));
                sub = 4'($urandom_range(15, 0));
            end else begin
                case ($urandom_range(5, 0))
                    0:       op = 4'd1;
                    1:       op = 4'd3;
                    2:       op = 4'd6;
                    3:       op = 4'd7;
                    4:       op = 4'd8;
                    default: op = 4'd10;
                endcase
                sub = 4'($urandom_range(15, maxSubOp(op) + 1)); // Past the last variant
            end
        end else begin
            op  = 4'($urandom_range(10, 0));
            sub = 4'($urandom_range(maxSubOp(op), 0));
        end
        return {op, sub};
    endfunction

    // Cycles per instruction including the fetch
    function automatic int expectedCycles(input logic [7:0] ins, input logic z);
        case (ins[7:4])
            4'd1:    return (ins[3:0] <= 2) ? (z ? 5 : 7) : 4;
            4'd2:    return (ins[1:0] == 2'd3) ? 7 : 8;
            4'd3:    return (ins[3:0] <= 1) ? 6 : 4;
            4'd4:    return 6;
            4'd5:    return (ins[1:0] == 2'd3) ? 5 : 6;
            default: return 4;
        endcase
    endfunction

    task automatic compareOutputs();
        string name;
        name = testName(mState);
        if (memRead && memWrite) begin
            $display("memRead and memWrite are high together in %s", name);
            abortRun();
        end
        checkStrobes(name, expStrobes, {iRomRead, memRead, memWrite, selAr});
        checkWen(name, expWen, wEn);
        checkBusSel(name, expBus, busSel);
        checkField({name, " incEn"}, expInc, incEn);
        checkField({name, " rstEn"}, {1'b0, expRst}, {1'b0, rstEn});
        checkField({name, " compSel"}, {3'b000, expCmp}, {3'b000, compSel});
        checkAluOp(name, expAlu, aluOp);
    endtask

    // Length of each instruction, IR write to IR write
    task automatic trackCycles();
        sinceIr++;
        if ((wEn & W_IR) != '0) begin
            if (insDone > 0) begin
                checkCount($sformatf("cycle count ins %h", regIr),
                           expectedCycles(regIr, jmpZero), sinceIr);
            end
            insDone++;
            sinceIr = 0;
        end
    endtask

    task automatic driveDatapath();
        if ((wEn & W_IR) != '0) begin
            regIr = randomInstruction(); // Byte read in FETCH1 lands in IR
        end
        zero = 1'($urandom_range(1, 0));
        if (sinceIr == 2) begin
            jmpZero = zero; // Flag seen by a JMP1 state
        end
    endtask

    initial begin
        rst   = 1'b1;
        regIr = '0;
        zero  = 1'b0;
        void'($urandom(32'he128));

        repeat (RST_CYCLES) begin
            @(posedge Clk);
            stepModel(rst, regIr, zero);
            #DRV_DLY;
            compareOutputs();
        end
        rst = 1'b0;

        while (insDone <= NUM_INS) begin
            @(posedge Clk);
            stepModel(rst, regIr, zero);
            #DRV_DLY;
            compareOutputs();
            trackCycles();
            driveDatapath();
        end

        $display("Test passed");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_INS + 1) * MAX_CYC * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("Watchdog expired, the run hung after %0d instructions", insDone);
        abortRun();
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module controlUnit
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic                 Clk,
    input  logic                 rst,
    input  insWordT              regIr,
    input  logic                 zero,
    output logic                 iRomRead,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 selAr,
    output wenMaskT              wEn,
    output busSelT               busSel,
    output logic [`CU_INC_W-1:0] incEn,
    output logic [`CU_RST_W-1:0] rstEn,
    output logic [`CU_CMP_W-1:0] compSel,
    output aluOpT                aluOp
);

    cuStateT entryState;
    cuStateT state;
    targetT  target;

    insDecoder u_decoder (
        .regIr      (regIr),
        .entryState (entryState),
        .target     (target)
    );

    cuSequencer u_sequencer (
        .Clk        (Clk),
        .rst        (rst),
        .entryState (entryState),
        .target     (target),
        .zero       (zero),
        .state      (state)
    );

    // Moore outputs, straight from the state register
    ctrlWordRom u_ctrlWord (
        .state    (state),
        .iRomRead (iRomRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .selAr    (selAr),
        .wEn      (wEn),
        .busSel   (busSel),
        .incEn    (incEn),
        .rstEn    (rstEn),
        .compSel  (compSel),
        .aluOp    (aluOp)
    );

endmodule

// File: hw/ctrlWordRom.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module ctrlWordRom
    import ctrlPkg::*;
(
    input  cuStateT              state,
    output logic                 iRomRead,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 selAr,
    output wenMaskT              wEn,
    output busSelT               busSel,
    output logic [`CU_INC_W-1:0] incEn,
    output logic [`CU_RST_W-1:0] rstEn,
    output logic [`CU_CMP_W-1:0] compSel,
    output aluOpT                aluOp
);

    always_comb begin
        iRomRead = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        selAr    = 1'b0;
        wEn      = '0;
        busSel   = BUS_NONE;
        incEn    = '0;
        rstEn    = '0;
        compSel  = '0;
        aluOp    = ALU_NONE;

        case (state)
            // ROM read of the next byte at PC, data on the bus one state later
            FETCH1, JMP2, COPY1, ASSIGN1: iRomRead = 1'b1;
            FETCH2: begin
                wEn[WEN_IR]   = 1'b1;
                incEn[INC_PC] = 1'b1;
            end
            FETCH3, NJMP1: incEn[INC_PC] = 1'b1;

            JMPM1: compSel[CMP_M] = 1'b1;
            JMPK1: compSel[CMP_K] = 1'b1;
            JMPN1: compSel[CMP_N] = 1'b1;
            JMP3:  wEn[WEN_AR] = 1'b1; // Jump address from ROM
            JMP4: begin
                wEn[WEN_PC] = 1'b1;
                busSel      = BUS_AR;
            end

            // Operand address byte into AR, skip over it in the ROM
            COPY2, ASSIGN2: begin
                wEn[WEN_AR]   = 1'b1;
                selAr         = 1'b1;
                incEn[INC_PC] = 1'b1;
            end
            COPY3, LOAD2: memRead = 1'b1;
            COPY4, LOAD3: begin
                wEn[WEN_DR] = 1'b1;
                busSel      = BUS_MEM;
            end
            COPYM5: begin
                wEn[WEN_M1] = 1'b1;
                busSel      = BUS_DR;
            end
            COPYK5: begin
                wEn[WEN_K1] = 1'b1;
                busSel      = BUS_DR;
            end
            COPYN5: begin
                wEn[WEN_N1] = 1'b1;
                busSel      = BUS_DR;
            end

            LOADC1: begin
                wEn[WEN_AR] = 1'b1;
                busSel      = BUS_C1;
            end
            LOADC2: begin
                wEn[WEN_AR] = 1'b1;
                busSel      = BUS_C2;
            end

            STORE1: begin
                wEn[WEN_DR] = 1'b1; // Result tile value
                busSel      = BUS_T;
            end
            STORE2: begin
                wEn[WEN_AR] = 1'b1;
                busSel      = BUS_C3;
            end
            STORE3: begin
                memWrite = 1'b1;
                busSel   = BUS_DR;
            end

            ASSIGNC1: begin
                wEn[WEN_C1] = 1'b1;
                busSel      = BUS_AR;
            end
            ASSIGNC2: begin
                wEn[WEN_C2] = 1'b1;
                busSel      = BUS_AR;
            end
            ASSIGNC3: begin
                wEn[WEN_C3] = 1'b1;
                busSel      = BUS_AR;
            end

            RESETALL: begin
                rstEn[RST_T]  = 1'b1;
                rstEn[RST_M2] = 1'b1;
                rstEn[RST_K2] = 1'b1;
                rstEn[RST_N2] = 1'b1;
                rstEn[RST_AC] = 1'b1;
            end
            RESETN2: rstEn[RST_N2] = 1'b1;
            RESETK2: rstEn[RST_K2] = 1'b1;

            // AC copied out to P, T or C1
            MOVEP: begin
                wEn[WEN_P] = 1'b1;
                busSel     = BUS_AC;
            end
            MOVET: begin
                wEn[WEN_T] = 1'b1;
                busSel     = BUS_AC;
            end
            MOVEC1: begin
                wEn[WEN_C1] = 1'b1;
                busSel      = BUS_AC;
            end

            SETC1, SETDR: begin
                wEn[WEN_AC] = 1'b1;
                busSel      = (state == SETC1) ? BUS_C1 : BUS_DR;
                aluOp       = ALU_SET;
            end
            MUL1: begin
                wEn[WEN_AC] = 1'b1; // AC times P
                busSel      = BUS_P;
                aluOp       = ALU_MUL;
            end
            ADDRT, ADDRM1, ADDRM2: begin
                wEn[WEN_AC] = 1'b1;
                aluOp       = ALU_ADD;
                case (state)
                    ADDRT:   busSel = BUS_T;
                    ADDRM1:  busSel = BUS_M1;
                    default: busSel = BUS_M2;
                endcase
            end

            default: ; // NOOP keeps everything low
        endcase
    end

    // Checked on the word of each state as it is left
    assert property (@(state) !(memRead && memWrite))
    else
        $error("ctrlWordRom: memRead and memWrite together");

    assert property (@(state) !(iRomRead && memRead))
    else
        $error("ctrlWordRom: ROM read and memory read share the bus");

    assert property (@(state) $onehot0(compSel))
    else
        $error("ctrlWordRom: more than one comparator selected");

endmodule

// File: hw/cuSequencer.sv
`timescale 1ns/1ps

module cuSequencer
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    input  cuStateT entryState,
    input  targetT  target,
    input  logic    zero,
    output cuStateT state
);

    cuStateT nextState;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= NOOP;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = FETCH1; // Last state of every instruction
        case (state)
            NOOP:   nextState = FETCH1;
            FETCH1: nextState = FETCH2;
            FETCH2: nextState = FETCH3;
            FETCH3: nextState = entryState; // IR was written in FETCH2

            // Zero flag from the selected comparator
            JMPM1, JMPK1, JMPN1: begin
                if (zero) begin
                    nextState = NJMP1;
                end else begin
                    nextState = JMP2;
                end
            end
            JMP2: nextState = JMP3;
            JMP3: nextState = JMP4;

            COPY1: nextState = COPY2;
            COPY2: nextState = COPY3;
            COPY3: nextState = COPY4;
            COPY4: begin
                case (target)
                    2'd0:    nextState = COPYM5;
                    2'd1:    nextState = COPYK5;
                    2'd2:    nextState = COPYN5;
                    default: nextState = FETCH1; // No register behind code 3
                endcase
            end

            LOADC1, LOADC2: nextState = LOAD2;
            LOAD2:          nextState = LOAD3;

            STORE1: nextState = STORE2;
            STORE2: nextState = STORE3;

            ASSIGN1: nextState = ASSIGN2;
            ASSIGN2: begin
                case (target)
                    2'd0:    nextState = ASSIGNC1;
                    2'd1:    nextState = ASSIGNC2;
                    2'd2:    nextState = ASSIGNC3;
                    default: nextState = FETCH1;
                endcase
            end

            default: nextState = FETCH1;
        endcase
    end

    // State register never leaves the enumeration once out of reset
    assert property (@(posedge Clk) disable iff (rst)
        !$isunknown(state) && (state <= ADDRM2))
    else
        $error("cuSequencer: state %0d outside the enumeration", state);

    // Reset and illegal instructions both resume with a fetch
    assert property (@(posedge Clk) disable iff (rst)
        state == NOOP |=> state == FETCH1)
    else
        $error("cuSequencer: NOOP not followed by FETCH1");

endmodule

// File: hw/insDecoder.sv
`timescale 1ns/1ps

module insDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  insWordT regIr,
    output cuStateT entryState,
    output targetT  target
);

    subOpT subOp;

    assign subOp  = regIr.grp.subOp;
    assign target = regIr.tgt.target; // Only looked at by COPY and ASSIGN

    always_comb begin
        entryState = NOOP; // Illegal groups and variants fall through to here
        case (regIr.grp.opcode)
            OP_JMP: begin
                case (subOp)
                    SUB_JMP_M: entryState = JMPM1;
                    SUB_JMP_K: entryState = JMPK1;
                    SUB_JMP_N: entryState = JMPN1;
                    default:   entryState = NOOP;
                endcase
            end
            OP_COPY:   entryState = COPY1;
            OP_LOAD: begin
                case (subOp)
                    SUB_LOAD_C1: entryState = LOADC1;
                    SUB_LOAD_C2: entryState = LOADC2;
                    default:     entryState = NOOP;
                endcase
            end
            OP_STORE:  entryState = STORE1;
            OP_ASSIGN: entryState = ASSIGN1;
            OP_RESET: begin
                case (subOp)
                    SUB_RST_ALL: entryState = RESETALL;
                    SUB_RST_N2:  entryState = RESETN2;
                    SUB_RST_K2:  entryState = RESETK2;
                    default:     entryState = NOOP;
                endcase
            end
            OP_MOVE: begin
                case (subOp)
                    SUB_MOVE_P:  entryState = MOVEP;
                    SUB_MOVE_T:  entryState = MOVET;
                    SUB_MOVE_C1: entryState = MOVEC1;
                    default:     entryState = NOOP;
                endcase
            end
            OP_SET: begin
                case (subOp)
                    SUB_SET_C1: entryState = SETC1;
                    SUB_SET_DR: entryState = SETDR;
                    default:    entryState = NOOP;
                endcase
            end
            OP_MUL:    entryState = MUL1;
            OP_ADD: begin
                case (subOp)
                    SUB_ADD_T:  entryState = ADDRT;
                    SUB_ADD_M1: entryState = ADDRM1;
                    SUB_ADD_M2: entryState = ADDRM2;
                    default:    entryState = NOOP;
                endcase
            end
            default:   entryState = NOOP;
        endcase
    end

endmodule

// File: hw/ctrlPkg.sv
`include "cu_params.svh"

package ctrlPkg;

    // One state per clock; ADDRM2 is kept as the highest code
    typedef enum logic [5:0] {
        NOOP,
        FETCH1, FETCH2, FETCH3,
        JMPM1, JMPK1, JMPN1,
        JMP2, JMP3, JMP4,
        NJMP1,
        COPY1, COPY2, COPY3, COPY4,
        COPYM5, COPYK5, COPYN5,
        LOADC1, LOADC2, LOAD2, LOAD3,
        STORE1, STORE2, STORE3,
        ASSIGN1, ASSIGN2,
        ASSIGNC1, ASSIGNC2, ASSIGNC3,
        RESETALL, RESETN2, RESETK2,
        MOVEP, MOVET, MOVEC1,
        SETC1, SETDR,
        MUL1,
        ADDRT, ADDRM1, ADDRM2
    } cuStateT;

    typedef logic [`CU_WEN_W-1:0] wenMaskT;

    // Write-enable bit of each register
    localparam int WEN_PC = 12;
    localparam int WEN_IR = 11;
    localparam int WEN_AR = 10;
    localparam int WEN_DR = 9;
    localparam int WEN_P  = 8;
    localparam int WEN_T  = 7;
    localparam int WEN_M1 = 6;
    localparam int WEN_K1 = 5;
    localparam int WEN_N1 = 4;
    localparam int WEN_C1 = 3;
    localparam int WEN_C2 = 2;
    localparam int WEN_C3 = 1;
    localparam int WEN_AC = 0;

    localparam int INC_PC = 5; // Only increment still in use

    // Clear strobe bits
    localparam int RST_T  = 4;
    localparam int RST_M2 = 3;
    localparam int RST_K2 = 2;
    localparam int RST_N2 = 1;
    localparam int RST_AC = 0;

    // Comparator pairs
    localparam int CMP_M = 2;
    localparam int CMP_K = 1;
    localparam int CMP_N = 0;

    typedef enum logic [`CU_BUS_W-1:0] {
        BUS_NONE = 4'd0,
        BUS_AC   = 4'd1,
        BUS_C3   = 4'd2,
        BUS_C2   = 4'd3,
        BUS_C1   = 4'd4,
        BUS_M2   = 4'd7,
        BUS_N1   = 4'd8,
        BUS_K1   = 4'd9,
        BUS_M1   = 4'd10,
        BUS_T    = 4'd11,
        BUS_P    = 4'd12,
        BUS_DR   = 4'd13,
        BUS_AR   = 4'd14,
        BUS_MEM  = 4'd15  // Data memory or instruction ROM read data
    } busSelT;

    typedef enum logic [`CU_ALU_W-1:0] {
        ALU_NONE = 3'b000,
        ALU_SET  = 3'b001,
        ALU_MUL  = 3'b010,
        ALU_ADD  = 3'b100
    } aluOpT;

endpackage

// File: hw/isaPkg.sv
`include "cu_params.svh"

package isaPkg;

    // Instruction group in the upper nibble
    typedef enum logic [`CU_INS_W/2-1:0] {
        OP_NOOP   = 4'd0,
        OP_JMP    = 4'd1,
        OP_COPY   = 4'd2,
        OP_LOAD   = 4'd3,
        OP_STORE  = 4'd4,
        OP_ASSIGN = 4'd5,
        OP_RESET  = 4'd6,
        OP_MOVE   = 4'd7,
        OP_SET    = 4'd8,
        OP_MUL    = 4'd9,
        OP_ADD    = 4'd10
    } opcodeT;

    typedef logic [`CU_INS_W/2-1:0] subOpT;
    typedef logic [1:0] targetT;

    // Variant codes within each group
    localparam subOpT SUB_JMP_M    = 4'd0; // Compare M1 with M2
    localparam subOpT SUB_JMP_K    = 4'd1;
    localparam subOpT SUB_JMP_N    = 4'd2;
    localparam subOpT SUB_LOAD_C1  = 4'd0;
    localparam subOpT SUB_LOAD_C2  = 4'd1;
    localparam subOpT SUB_RST_ALL  = 4'd0;
    localparam subOpT SUB_RST_N2   = 4'd1;
    localparam subOpT SUB_RST_K2   = 4'd2;
    localparam subOpT SUB_MOVE_P   = 4'd0;
    localparam subOpT SUB_MOVE_T   = 4'd1;
    localparam subOpT SUB_MOVE_C1  = 4'd2;
    localparam subOpT SUB_SET_C1   = 4'd0;
    localparam subOpT SUB_SET_DR   = 4'd1;
    localparam subOpT SUB_ADD_T    = 4'd0;
    localparam subOpT SUB_ADD_M1   = 4'd1;
    localparam subOpT SUB_ADD_M2   = 4'd2;

    // COPY and ASSIGN read the low two bits as a register target
    typedef union packed {
        struct packed {
            opcodeT opcode;
            subOpT  subOp;
        } grp;
        struct packed {
            opcodeT     opcode;
            logic [1:0] unused;
            targetT     target; // COPY M1/K1/N1, ASSIGN C1/C2/C3
        } tgt;
    } insWordT;

endpackage

// File: hw/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction byte fetched from the instruction ROM
`define CU_INS_W 8

// Register write enables, PC down to AC
`define CU_WEN_W 13

// Datapath bus source select
`define CU_BUS_W 4

// Increment strobes, only the PC bit is still driven
`define CU_INC_W 6

// Clear strobes for T, M2, K2, N2 and AC
`define CU_RST_W 5

// Comparator pair select, one-hot
`define CU_CMP_W 3

// ALU operation, one-hot
`define CU_ALU_W 3

`endif
